// ==== rtl/board_cfg_pkg.sv ====
// Board configuration types
package board_cfg_pkg;

  ////////////////////
  // Fan control
  ////////////////////

  // Fan duty in sixteenths of a PWM frame, 0 keeps the fan off
  typedef logic [3:0] duty_t;

  // One slot per duty step, so a full frame holds 16 slots
  localparam int unsigned PwmSlots = 2 ** $bits(duty_t);

  ////////////////////
  // Boot straps
  ////////////////////

  // SoC boot mode as seen on the strap pins
  //   2'd0  passive, wait for debugger
  //   2'd1  SPI SD card
  //   2'd2  SPI flash
  //   2'd3  reserved
  typedef logic [1:0] boot_mode_t;

endpackage

// ==== rtl/board_cmd_pkg.sv ====
// Board command word encodings
package board_cmd_pkg;

  ////////////////////
  // Opcodes
  ////////////////////

  // Top two bits of every command word
  // 2'd3 has no meaning and is flagged as an error
  typedef enum logic [1:0] {
    OP_NOP  = 2'd0,
    OP_FAN  = 2'd1,
    OP_BOOT = 2'd2
  } board_op_e;

  ////////////////////
  // Command views
  ////////////////////

  // Fan duty update
  typedef struct packed {
    board_op_e            opcode;
    board_cfg_pkg::duty_t duty;
    logic [9:0]           rsvd;
  } fan_cmd_t;

  // Boot mode override
  typedef struct packed {
    board_op_e                 opcode;
    logic                      override_en;
    board_cfg_pkg::boot_mode_t boot_mode;
    logic [10:0]               rsvd;
  } boot_cmd_t;

  // Opcode sits in the same bits of both views
  typedef union packed {
    fan_cmd_t  fan;
    boot_cmd_t boot;
  } board_cmd_u;

endpackage

// ==== rtl/tick_divider.sv ====
// RTC and PWM slot tick divider
`timescale 1ns/1ps

module tick_divider #(
  parameter int unsigned RtcHalfDiv = 25,
  parameter int unsigned PwmSlotDiv = 4
) (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o,
  output logic slot_tick_o
);

  localparam int unsigned RtcCntW  = (RtcHalfDiv > 1) ? $clog2(RtcHalfDiv) : 1;
  localparam int unsigned SlotCntW = (PwmSlotDiv > 1) ? $clog2(PwmSlotDiv) : 1;

  localparam logic [RtcCntW-1:0]  RtcLast  = RtcCntW'(RtcHalfDiv - 1);
  localparam logic [SlotCntW-1:0] SlotLast = SlotCntW'(PwmSlotDiv - 1);

  logic [RtcCntW-1:0]  rtc_cnt_q;
  logic                rtc_q;
  logic [SlotCntW-1:0] slot_cnt_q;
  logic                slot_tick_q;

  ////////////////////
  // RTC half period
  ////////////////////

  // Toggle on the last count so each phase lasts RtcHalfDiv cycles
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      rtc_cnt_q <= '0;
      rtc_q     <= 1'b0;
    end else if (rtc_cnt_q == RtcLast) begin
      rtc_cnt_q <= '0;
      rtc_q     <= ~rtc_q;
    end else begin
      rtc_cnt_q <= rtc_cnt_q + 1'b1;
    end
  end

  ////////////////////
  // PWM slot tick
  ////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_cnt_q  <= '0;
      slot_tick_q <= 1'b0;
    end else begin
      slot_tick_q <= (slot_cnt_q == SlotLast);
      slot_cnt_q  <= (slot_cnt_q == SlotLast) ? '0 : slot_cnt_q + 1'b1;
    end
  end

  assign rtc_o       = rtc_q;
  assign slot_tick_o = slot_tick_q;

  // Downstream slot counter relies on isolated single-cycle ticks
  a_tick_single: assert property (@(posedge soc_clk) disable iff (!rst_n)
    (PwmSlotDiv > 1) && slot_tick_o |=> !slot_tick_o)
    else $error("slot tick held high for two cycles");

endmodule

// ==== rtl/fan_pwm.sv ====
// Fan PWM generator
`timescale 1ns/1ps

module fan_pwm (
  input  logic                 soc_clk,
  input  logic                 rst_n,
  input  logic                 slot_tick_i,
  input  board_cfg_pkg::duty_t duty_i,
  output logic                 fan_pwm_o
);

  import board_cfg_pkg::*;

  localparam int unsigned      SlotW    = $clog2(PwmSlots);
  localparam logic [SlotW-1:0] LastSlot = SlotW'(PwmSlots - 1);

  logic [SlotW-1:0] slot_cnt_q;
  logic [SlotW-1:0] slot_cnt_d;
  duty_t            duty_q;
  duty_t            duty_d;
  logic             pwm_q;

  ////////////////////
  // Slot counter
  ////////////////////

  // Duty only changes at frame start so a frame is never cut short
  always_comb begin
    slot_cnt_d = slot_cnt_q;
    duty_d     = duty_q;
    if (slot_tick_i) begin
      if (slot_cnt_q == LastSlot) begin
        slot_cnt_d = '0;
        duty_d     = duty_i;
      end else begin
        slot_cnt_d = slot_cnt_q + 1'b1;
      end
    end
  end

  // Output follows the slot counter in the same cycle
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_cnt_q <= '0;
      duty_q     <= '0;
      pwm_q      <= 1'b0;
    end else begin
      slot_cnt_q <= slot_cnt_d;
      duty_q     <= duty_d;
      pwm_q      <= (slot_cnt_d < duty_d);
    end
  end

  assign fan_pwm_o = pwm_q;

  // Zero duty keeps the fan off for the whole frame
  a_zero_duty_off: assert property (@(posedge soc_clk) disable iff (!rst_n)
    (duty_q == '0) |-> !fan_pwm_o)
    else $error("fan output high with zero latched duty");

endmodule

// ==== rtl/board_cmd_fsm.sv ====
// Board command FSM
`timescale 1ns/1ps

module board_cmd_fsm (
  input  logic                      soc_clk,
  input  logic                      rst_n,
  input  logic                      cmd_req_i,
  input  board_cmd_pkg::board_cmd_u cmd_word_i,
  output logic                      cmd_ack_o,
  output logic                      cmd_err_o,
  input  board_cfg_pkg::boot_mode_t boot_mode_i,
  output board_cfg_pkg::boot_mode_t boot_mode_o,
  output board_cfg_pkg::duty_t      fan_duty_o
);

  import board_cfg_pkg::*;
  import board_cmd_pkg::*;

  localparam logic [1:0] IDLE    = 2'd0;
  localparam logic [1:0] DECODE  = 2'd1;
  localparam logic [1:0] ACK     = 2'd2;
  localparam logic [1:0] RELEASE = 2'd3;

  logic [1:0] state_q;
  logic [1:0] state_d;

  // Latched command and decode stage
  board_cmd_u cmd_q;
  logic       op_fan;
  logic       op_boot;
  logic       op_err;
  logic       dec_fan_q;
  logic       dec_boot_q;
  logic       dec_err_q;
  duty_t      dec_duty_q;
  logic       dec_ovr_en_q;
  boot_mode_t dec_mode_q;

  // Architectural state
  duty_t      fan_duty_q;
  logic       ovr_en_q;
  boot_mode_t ovr_mode_q;
  logic       ack_q;
  logic       err_q;

  ////////////////////
  // Handshake FSM
  ////////////////////

  // A slow host simply parks the FSM in RELEASE
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (cmd_req_i) state_d = DECODE;
      DECODE:  state_d = ACK;
      ACK:     state_d = RELEASE;
      RELEASE: if (!cmd_req_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // Opcode is read through the fan view, both views share it
  always_comb begin
    op_fan  = 1'b0;
    op_boot = 1'b0;
    op_err  = 1'b0;
    case (cmd_q.fan.opcode)
      OP_NOP:  op_err  = 1'b0;
      OP_FAN:  op_fan  = 1'b1;
      OP_BOOT: op_boot = 1'b1;
      default: op_err  = 1'b1;
    endcase
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= IDLE;
      dec_fan_q  <= 1'b0;
      dec_boot_q <= 1'b0;
      dec_err_q  <= 1'b0;
      fan_duty_q <= '0;
      ovr_en_q   <= 1'b0;
      ack_q      <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == DECODE) begin
        dec_fan_q  <= op_fan;
        dec_boot_q <= op_boot;
        dec_err_q  <= op_err;
      end
      // Apply cycle, new settings appear together with ack
      if (state_q == ACK) begin
        ack_q <= 1'b1;
        err_q <= dec_err_q;
        if (dec_fan_q) fan_duty_q <= dec_duty_q;
        if (dec_boot_q) ovr_en_q <= dec_ovr_en_q;
      end
      if (state_q == RELEASE && !cmd_req_i) begin
        ack_q <= 1'b0;
        err_q <= 1'b0;
      end
    end
  end

  ////////////////////
  // Command payload
  ////////////////////

  always_ff @(posedge soc_clk) begin
    if (state_q == IDLE && cmd_req_i) cmd_q <= cmd_word_i;
    if (state_q == DECODE) begin
      dec_duty_q   <= cmd_q.fan.duty;
      dec_ovr_en_q <= cmd_q.boot.override_en;
      dec_mode_q   <= cmd_q.boot.boot_mode;
    end
    if (state_q == ACK && dec_boot_q) ovr_mode_q <= dec_mode_q;
  end

  assign cmd_ack_o  = ack_q;
  assign cmd_err_o  = err_q;
  assign fan_duty_o = fan_duty_q;

  // Strap passes straight through unless overridden
  assign boot_mode_o = ovr_en_q ? ovr_mode_q : boot_mode_i;

  ////////////////////
  // Protocol checks
  ////////////////////

  a_word_stable: assert property (@(posedge soc_clk) disable iff (!rst_n)
    cmd_req_i |=> !cmd_req_i || $stable(cmd_word_i))
    else $error("command word changed while req high");

  a_ack_hold: assert property (@(posedge soc_clk) disable iff (!rst_n)
    cmd_ack_o && cmd_req_i |=> cmd_ack_o)
    else $error("ack dropped before req was released");

endmodule

// ==== rtl/board_ctrl_top.sv ====
// Board control top level
`timescale 1ns/1ps

module board_ctrl_top #(
  parameter int unsigned RtcHalfDiv = 25,
  parameter int unsigned PwmSlotDiv = 4
) (
  input  logic                      soc_clk,
  input  logic                      rst_n,
  input  logic                      cmd_req_i,
  input  board_cmd_pkg::board_cmd_u cmd_word_i,
  output logic                      cmd_ack_o,
  output logic                      cmd_err_o,
  input  board_cfg_pkg::boot_mode_t boot_mode_i,
  output board_cfg_pkg::boot_mode_t boot_mode_o,
  output logic                      rtc_o,
  output logic                      fan_pwm_o
);

  import board_cfg_pkg::*;

  duty_t fan_duty;
  logic  slot_tick;

  ////////////////////
  // Command port
  ////////////////////

  board_cmd_fsm i_cmd_fsm (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_n       ),
    .cmd_req_i   ( cmd_req_i   ),
    .cmd_word_i  ( cmd_word_i  ),
    .cmd_ack_o   ( cmd_ack_o   ),
    .cmd_err_o   ( cmd_err_o   ),
    .boot_mode_i ( boot_mode_i ),
    .boot_mode_o ( boot_mode_o ),
    .fan_duty_o  ( fan_duty    )
  );

  ////////////////////
  // Clock dividers
  ////////////////////

  // 50 MHz soc_clk down to 1 MHz RTC with the default divider
  tick_divider #(
    .RtcHalfDiv ( RtcHalfDiv ),
    .PwmSlotDiv ( PwmSlotDiv )
  ) i_tick_divider (
    .soc_clk     ( soc_clk   ),
    .rst_n       ( rst_n     ),
    .rtc_o       ( rtc_o     ),
    .slot_tick_o ( slot_tick )
  );

  ////////////////////
  // Fan PWM
  ////////////////////

  fan_pwm i_fan_pwm (
    .soc_clk     ( soc_clk   ),
    .rst_n       ( rst_n     ),
    .slot_tick_i ( slot_tick ),
    .duty_i      ( fan_duty  ),
    .fan_pwm_o   ( fan_pwm_o )
  );

endmodule

// ==== tb/board_ctrl_tb.sv ====
// Board control testbench
`timescale 1ns/1ps

module board_ctrl_tb;

  import board_cfg_pkg::*;
  import board_cmd_pkg::*;

  localparam int RtcHalfDiv  = 25;
  localparam int PwmSlotDiv  = 4;
  localparam int FrameCycles = int'(PwmSlots) * PwmSlotDiv;
  localparam int CmdCycles   = 10;
  localparam int MaxAckWait  = 8;
  // 40 frames and 40 commands, plus room for the RTC phases
  localparam int WatchdogCycles = 40 * FrameCycles + 40 * CmdCycles + 8 * RtcHalfDiv;

  logic       soc_clk;
  logic       rst_n;
  logic       cmd_req;
  board_cmd_u cmd_word;
  logic       cmd_ack;
  logic       cmd_err;
  boot_mode_t strap;
  boot_mode_t boot_mode;
  logic       rtc;
  logic       fan_pwm;

  integer     seed;
  int         errors;
  int         err_mark;
  int         tests_passed;
  int         tests_failed;

  // Expected DUT state
  duty_t      model_duty;
  logic       model_ovr_en;
  boot_mode_t model_ovr_mode;

  board_ctrl_top #(
    .RtcHalfDiv ( RtcHalfDiv ),
    .PwmSlotDiv ( PwmSlotDiv )
  ) i_dut (
    .soc_clk     ( soc_clk   ),
    .rst_n       ( rst_n     ),
    .cmd_req_i   ( cmd_req   ),
    .cmd_word_i  ( cmd_word  ),
    .cmd_ack_o   ( cmd_ack   ),
    .cmd_err_o   ( cmd_err   ),
    .boot_mode_i ( strap     ),
    .boot_mode_o ( boot_mode ),
    .rtc_o       ( rtc       ),
    .fan_pwm_o   ( fan_pwm   )
  );

  initial soc_clk = 1'b0;
  always #2 soc_clk = ~soc_clk;

  ////////////////////
  // Reference model
  ////////////////////

  function automatic boot_mode_t exp_boot(input logic ovr_en, input boot_mode_t ovr_mode,
                                          input boot_mode_t strap_val);
    return ovr_en ? ovr_mode : strap_val;
  endfunction

  // Each duty step is one slot of PwmSlotDiv cycles
  function automatic int exp_high_count(input duty_t duty);
    return int'(duty) * PwmSlotDiv;
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic note_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic check_boot(input boot_mode_t got, input boot_mode_t exp, input string what);
    if (got !== exp) note_error($sformatf("%s: boot mode %0d, expected %0d", what, got, exp));
  endtask

  task automatic check_duty_count(input duty_t duty, input int high_cycles);
    int exp;
    exp = exp_high_count(duty);
    if (high_cycles != exp)
      note_error($sformatf("duty %0d: %0d high cycles per frame, expected %0d",
                           duty, high_cycles, exp));
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) note_error($sformatf("%s: err %b, expected %b", what, got, exp));
  endtask

  task automatic check_rtc(input logic level, input int cycles);
    if (cycles != RtcHalfDiv)
      note_error($sformatf("rtc %b phase lasted %0d cycles, expected %0d",
                           level, cycles, RtcHalfDiv));
  endtask

  task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp) note_error($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  ////////////////////
  // Host actions
  ////////////////////

  // Four-phase handshake, returns err as seen when ack rises
  task automatic send_cmd(input board_cmd_u word, output logic err);
    int lat;
    lat = 0;
    @(posedge soc_clk);
    cmd_word <= word;
    cmd_req  <= 1'b1;
    // First edge that samples req high
    @(posedge soc_clk);
    @(negedge soc_clk);
    while (!cmd_ack && lat < MaxAckWait) begin
      @(posedge soc_clk);
      lat++;
      @(negedge soc_clk);
    end
    if (!cmd_ack) begin
      $display("no ack from the DUT within %0d cycles of req", MaxAckWait);
      errors++;
    end else if (lat != 2) begin
      note_error($sformatf("ack rose %0d cycles after req, expected 2", lat));
    end
    err = cmd_err;
    @(posedge soc_clk);
    cmd_req <= 1'b0;
    @(negedge soc_clk);
    if (!cmd_ack || cmd_err !== err) note_error("ack or err changed before req was seen low");
    // Edge that samples req low, ack drops here
    @(posedge soc_clk);
    @(negedge soc_clk);
    check_level("ack one cycle after release", cmd_ack, 1'b0);
  endtask

  task automatic drive_strap_and_check(input string what);
    @(posedge soc_clk);
    strap <= boot_mode_t'($random(seed));
    @(negedge soc_clk);
    check_boot(boot_mode, exp_boot(model_ovr_en, model_ovr_mode, strap), what);
  endtask

  task automatic count_high_cycles(output int cnt);
    cnt = 0;
    repeat (FrameCycles) begin
      @(negedge soc_clk);
      if (fan_pwm) cnt++;
    end
  endtask

  task automatic start_test();
    err_mark = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == err_mark) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_mark);
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    board_cmd_u word;
    logic       err;
    logic       level;
    duty_t      duty;
    int         cnt;
    seed           = 32'hdcdc_1bcb;
    errors         = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    model_duty     = '0;
    model_ovr_en   = 1'b0;
    model_ovr_mode = '0;
    rst_n          = 1'b0;
    cmd_req        = 1'b0;
    cmd_word       = '0;
    strap          = '0;
    repeat (5) @(posedge soc_clk);
    rst_n <= 1'b1;

    start_test();
    repeat (3) @(negedge soc_clk);
    check_level("ack after reset", cmd_ack, 1'b0);
    check_err(cmd_err, 1'b0, "after reset");
    check_level("fan pwm after reset", fan_pwm, 1'b0);
    check_level("rtc after reset", rtc, 1'b0);
    repeat (4) drive_strap_and_check("strap after reset");
    end_test("reset");

    start_test();
    @(negedge soc_clk);
    level = rtc;
    while (rtc == level) @(negedge soc_clk);
    repeat (4) begin
      level = rtc;
      cnt   = 1;
      @(negedge soc_clk);
      while (rtc == level && cnt <= 2 * RtcHalfDiv) begin
        cnt++;
        @(negedge soc_clk);
      end
      check_rtc(level, cnt);
    end
    end_test("rtc");

    // Last duty is 15 so later tests see a nonzero setting
    start_test();
    for (int i = 0; i < 6; i++) begin
      if (i == 0) duty = '0;
      else if (i == 5) duty = 4'd15;
      else duty = duty_t'($random(seed));
      word          = '0;
      word.fan.opcode = OP_FAN;
      word.fan.duty = duty;
      send_cmd(word, err);
      check_err(err, 1'b0, "fan command");
      model_duty = duty;
      repeat (2 * FrameCycles) @(negedge soc_clk);
      count_high_cycles(cnt);
      check_duty_count(model_duty, cnt);
    end
    end_test("fan duty");

    start_test();
    word                  = '0;
    word.boot.opcode      = OP_BOOT;
    word.boot.override_en = 1'b1;
    word.boot.boot_mode   = boot_mode_t'($random(seed));
    send_cmd(word, err);
    check_err(err, 1'b0, "boot override on");
    model_ovr_en   = 1'b1;
    model_ovr_mode = word.boot.boot_mode;
    repeat (4) drive_strap_and_check("override on");
    word.boot.override_en = 1'b0;
    word.boot.boot_mode   = boot_mode_t'($random(seed));
    send_cmd(word, err);
    check_err(err, 1'b0, "boot override off");
    model_ovr_en = 1'b0;
    repeat (4) drive_strap_and_check("override off");
    end_test("boot override");

    // Random payloads must not leak into any register
    start_test();
    word          = board_cmd_u'(16'($random(seed)));
    word[15:14]   = 2'b11;
    send_cmd(word, err);
    check_err(err, 1'b1, "illegal opcode");
    repeat (4) drive_strap_and_check("after illegal opcode");
    // A leaked duty would be latched by the next frame start
    repeat (2 * FrameCycles) @(negedge soc_clk);
    count_high_cycles(cnt);
    check_duty_count(model_duty, cnt);
    word            = board_cmd_u'(16'($random(seed)));
    word.fan.opcode = OP_NOP;
    send_cmd(word, err);
    check_err(err, 1'b0, "nop");
    repeat (4) drive_strap_and_check("after nop");
    repeat (2 * FrameCycles) @(negedge soc_clk);
    count_high_cycles(cnt);
    check_duty_count(model_duty, cnt);
    end_test("command errors");

    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  ////////////////////
  // Watchdog
  ////////////////////

  initial begin
    repeat (WatchdogCycles) @(posedge soc_clk);
    $display("timeout: tests still running after %0d clock cycles", WatchdogCycles);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== compile.f ====
rtl/board_cfg_pkg.sv
rtl/board_cmd_pkg.sv
rtl/tick_divider.sv
rtl/fan_pwm.sv
rtl/board_cmd_fsm.sv
rtl/board_ctrl_top.sv
tb/board_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the board control testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=board_ctrl_sim
LOG=sim.log

verilator --binary --timing --assert -f compile.f \
  --top-module board_ctrl_tb -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./"$BUILD_DIR"/"$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
  echo "simulation log has no result line"
  exit 1
fi
exit 0
